/* verilog/csr_cfg_defs.svh */
/*
 * Widths and sizes shared by the CSR index configuration loader.
 * CFG_SEQ_W must cover CFG_SEQ_LEN, and CFG_FIFO_DEPTH must be a power of two.
 */

`ifndef CSR_CFG_DEFS_SVH
`define CSR_CFG_DEFS_SVH

// --------------------
// Response link
// --------------------
`define CFG_DATA_W      32
`define CFG_OFFSET_W    8

// --------------------
// Configuration sequence
// --------------------
`define CFG_SEQ_LEN     8
`define CFG_SEQ_W       3

// Record field widths
`define CFG_SHIFT_W     5
`define CFG_CMD_W       4
`define CFG_ID_W        4

// Records buffered toward the consumer
`define CFG_FIFO_DEPTH  4

`endif

/* verilog/csr_cfg_pkg.sv */
/*
 * Types shared by every loader stage. The word views assume a 32-bit data word.
 */

`default_nettype none

`include "csr_cfg_defs.svh"

package csr_cfg_pkg;

    // One memory response word with its offset
    typedef struct packed {
        logic [`CFG_OFFSET_W-1:0] offset;
        logic [`CFG_DATA_W-1:0]   data;
    } response_t;

    // --------------------
    // Views of one data word
    // --------------------
    typedef struct packed {
        logic [`CFG_DATA_W-6:0] reserved;
        logic                   mode_break;
        logic                   mode_buffer;
        logic                   mode_sequence;
        logic                   decrement;
        logic                   increment;
    } mode_flags_t;

    // Direction sits in the top bit
    typedef struct packed {
        logic                                direction;
        logic [`CFG_DATA_W-`CFG_SHIFT_W-2:0] reserved;
        logic [`CFG_SHIFT_W-1:0]             granularity;
    } shift_ctrl_t;

    typedef struct packed {
        logic [`CFG_DATA_W-`CFG_CMD_W-2*`CFG_ID_W-1:0] reserved;
        logic [`CFG_ID_W-1:0]                          id_channel;
        logic [`CFG_ID_W-1:0]                          id_module;
        logic [`CFG_CMD_W-1:0]                         cmd;
    } route_ctrl_t;

    typedef union packed {
        logic [`CFG_DATA_W-1:0] raw;
        mode_flags_t            mode;
        shift_ctrl_t            shift;
        route_ctrl_t            route;
    } cfg_word_u;

    // --------------------
    // Configuration record
    // --------------------
    typedef struct packed {
        logic                    increment;
        logic                    decrement;
        logic                    mode_sequence;
        logic                    mode_buffer;
        logic                    mode_break;
        logic [`CFG_DATA_W-1:0]  index_start;
        logic [`CFG_DATA_W-1:0]  index_end;
        logic [`CFG_DATA_W-1:0]  stride;
        logic [`CFG_SHIFT_W-1:0] granularity;
        logic                    direction;
        logic [`CFG_CMD_W-1:0]   cmd;
        logic [`CFG_ID_W-1:0]    id_module;
        logic [`CFG_ID_W-1:0]    id_channel;
        logic [`CFG_DATA_W-1:0]  array_size;
        logic [`CFG_DATA_W-1:0]  const_value;
    } csr_index_cfg_t;

endpackage

`default_nettype wire

/* verilog/response_window_filter.sv */
/*
 * Registered stage; out-of-window words are taken and dropped.
 * Output offsets are relative to WINDOW_BASE.
 */

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg_defs.svh"

module response_window_filter
    import csr_cfg_pkg::*;
#(
    parameter logic [`CFG_OFFSET_W-1:0] WINDOW_BASE = 8'd16
) (
    input  wire logic      ap_clk,
    input  wire logic      areset_csr_index_generator,
    input  wire logic      resp_valid,
    input  wire response_t resp,
    output logic           resp_ready,
    output logic           win_valid,
    output response_t      win_word,
    input  wire logic      win_ready
);

    // One past the last offset of the window, one bit wider to avoid wrap
    localparam logic [`CFG_OFFSET_W:0] WINDOW_END =
        {1'b0, WINDOW_BASE} + (`CFG_OFFSET_W+1)'(`CFG_SEQ_LEN);

    logic ready_en;
    logic in_window;

    assign in_window = (resp.offset >= WINDOW_BASE) && ({1'b0, resp.offset} < WINDOW_END);

    // Held off for one cycle out of reset
    assign resp_ready = ready_en && (!win_valid || win_ready);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            ready_en  <= 1'b0;
            win_valid <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (resp_ready) begin
                win_valid <= resp_valid && in_window;
            end
        end
    end

    // Payload, rebased to the window position
    always_ff @(posedge ap_clk) begin
        if (resp_ready && resp_valid && in_window) begin
            win_word.offset <= resp.offset - WINDOW_BASE;
            win_word.data   <= resp.data;
        end
    end

    a_win_pos_in_range: assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        win_valid |-> (win_word.offset < `CFG_SEQ_LEN));

endmodule

`default_nettype wire

/* verilog/config_assembler.sv */
/*
 * Builds one record from window positions 0..7 taken strictly in order.
 * A word at position 0 restarts; any other out-of-order word drops the sequence.
 */

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg_defs.svh"

module config_assembler
    import csr_cfg_pkg::*;
(
    input  wire logic      ap_clk,
    input  wire logic      areset_csr_index_generator,
    input  wire logic      win_valid,
    input  wire response_t win_word,
    output logic           win_ready,
    output logic           rec_valid,
    output csr_index_cfg_t rec,
    input  wire logic      rec_ready
);

    logic [`CFG_SEQ_W-1:0] expect_pos;
    logic [`CFG_SEQ_W-1:0] pos;
    logic                  word_accept;
    logic                  word_take;
    cfg_word_u             word_view;

    assign pos       = win_word.offset[`CFG_SEQ_W-1:0];
    assign word_view = win_word.data;

    // Stall only while a finished record waits
    assign win_ready   = !rec_valid || rec_ready;
    assign word_accept = win_valid && win_ready;
    assign word_take   = word_accept && ((pos == '0) || (pos == expect_pos));

    // --------------------
    // Sequence tracking
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            expect_pos <= '0;
            rec_valid  <= 1'b0;
        end else begin
            if (rec_valid && rec_ready) begin
                rec_valid <= 1'b0;
            end
            if (word_take) begin
                // Last position wraps the counter back to 0
                expect_pos <= pos + 1'b1;
                if (pos == `CFG_SEQ_W'(`CFG_SEQ_LEN-1)) begin
                    rec_valid <= 1'b1;
                end
            end else if (word_accept) begin
                expect_pos <= '0;
            end
        end
    end

    // --------------------
    // Field decode
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (word_take) begin
            case (pos)
                3'd0: begin
                    rec.increment     <= word_view.mode.increment;
                    rec.decrement     <= word_view.mode.decrement;
                    rec.mode_sequence <= word_view.mode.mode_sequence;
                    rec.mode_buffer   <= word_view.mode.mode_buffer;
                    rec.mode_break    <= word_view.mode.mode_break;
                end
                3'd1: rec.index_start <= word_view.raw;
                3'd2: rec.index_end   <= word_view.raw;
                3'd3: rec.stride      <= word_view.raw;
                3'd4: begin
                    rec.granularity <= word_view.shift.granularity;
                    rec.direction   <= word_view.shift.direction;
                end
                3'd5: begin
                    rec.cmd        <= word_view.route.cmd;
                    rec.id_module  <= word_view.route.id_module;
                    rec.id_channel <= word_view.route.id_channel;
                end
                3'd6: rec.array_size  <= word_view.raw;
                3'd7: rec.const_value <= word_view.raw;
            endcase
        end
    end

    // Offered record may not change until the FIFO takes it
    a_rec_hold: assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        (rec_valid && !rec_ready) |=> (rec_valid && $stable(rec)));

endmodule

`default_nettype wire

/* verilog/config_fifo.sv */
/*
 * Circular record buffer followed by an output register.
 * Holds CFG_FIFO_DEPTH records plus the one on the output.
 */

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg_defs.svh"

module config_fifo
    import csr_cfg_pkg::*;
(
    input  wire logic           ap_clk,
    input  wire logic           areset_csr_index_generator,
    input  wire logic           rec_valid,
    input  wire csr_index_cfg_t rec,
    output logic                rec_ready,
    output logic                cfg_valid,
    output csr_index_cfg_t      cfg,
    input  wire logic           cfg_ready
);

    localparam int PTR_W = $clog2(`CFG_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`CFG_FIFO_DEPTH + 1);

    csr_index_cfg_t   mem [`CFG_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;
    logic             out_free;

    assign rec_ready = (count != CNT_W'(`CFG_FIFO_DEPTH));
    assign push      = rec_valid && rec_ready;
    assign out_free  = !cfg_valid || cfg_ready;
    assign pop       = out_free && (count != '0);

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            cfg_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (out_free) begin
                cfg_valid <= pop;
            end
        end
    end

    // Storage and output register
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= rec;
        end
        if (pop) begin
            cfg <= mem[rd_ptr];
        end
    end

    a_count_bound: assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        count <= CNT_W'(`CFG_FIFO_DEPTH));

    // Pointers must show a stored record whenever a pop happens
    a_no_pop_empty: assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        pop |-> ((wr_ptr != rd_ptr) || (count == CNT_W'(`CFG_FIFO_DEPTH))));

endmodule

`default_nettype wire

/* verilog/csr_index_configure.sv */
/*
 * CSR index configuration loader: window filter, assembler, record FIFO.
 * Every link is valid/ready, so back-pressure reaches the response input.
 */

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg_defs.svh"

module csr_index_configure
    import csr_cfg_pkg::*;
#(
    parameter logic [`CFG_OFFSET_W-1:0] WINDOW_BASE = 8'd16
) (
    input  wire logic           ap_clk,
    input  wire logic           areset_csr_index_generator,
    input  wire logic           resp_valid,
    input  wire response_t      resp,
    output logic                resp_ready,
    output logic                cfg_valid,
    output csr_index_cfg_t      cfg,
    input  wire logic           cfg_ready
);

    // Filter to assembler
    logic           win_valid;
    logic           win_ready;
    response_t      win_word;

    // Assembler to FIFO
    logic           rec_valid;
    logic           rec_ready;
    csr_index_cfg_t rec;

    response_window_filter #(
        .WINDOW_BASE(WINDOW_BASE)
    ) u_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp                      (resp),
        .resp_ready                (resp_ready),
        .win_valid                 (win_valid),
        .win_word                  (win_word),
        .win_ready                 (win_ready)
    );

    config_assembler u_assembler (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .win_valid                 (win_valid),
        .win_word                  (win_word),
        .win_ready                 (win_ready),
        .rec_valid                 (rec_valid),
        .rec                       (rec),
        .rec_ready                 (rec_ready)
    );

    config_fifo u_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .rec_valid                 (rec_valid),
        .rec                       (rec),
        .rec_ready                 (rec_ready),
        .cfg_valid                 (cfg_valid),
        .cfg                       (cfg),
        .cfg_ready                 (cfg_ready)
    );

endmodule

`default_nettype wire

/* dv/tb_csr_index_configure.sv */
/*
 * Testbench for the CSR index loader with WINDOW_BASE 16.
 * Expected records come from the decode map; stimulus is LFSR driven with seed 83.
 */

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg_defs.svh"

module tb_csr_index_configure
    import csr_cfg_pkg::*;
;

    localparam int CLK_PERIOD = 8;
    localparam logic [7:0] BASE = 8'd16;
    localparam int NUM_SEQ = 35;

    logic           ap_clk = 1'b0;
    logic           areset_csr_index_generator;
    logic           resp_valid;
    response_t      resp;
    logic           resp_ready;
    logic           cfg_valid;
    csr_index_cfg_t cfg;
    logic           cfg_ready;

    logic [15:0]      data_lfsr = 16'd83;
    logic [15:0]      ready_lfsr = 16'd83;
    bit               random_ready = 1'b0;
    csr_index_cfg_t   exp_q[$];
    csr_index_cfg_t   exp_rec;
    int               rec_count = 0;
    logic [7:0][31:0] words;
    logic [7:0][31:0] early_words;

    csr_index_configure #(
        .WINDOW_BASE(BASE)
    ) u_dut (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp                      (resp),
        .resp_ready                (resp_ready),
        .cfg_valid                 (cfg_valid),
        .cfg                       (cfg),
        .cfg_ready                 (cfg_ready)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    // --------------------
    // Helpers
    // --------------------
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    // Galois form, right shift, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_data_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], data_lfsr[0]};
            data_lfsr = lfsr_step(data_lfsr);
        end
        return val;
    endfunction

    function automatic logic take_ready_bit();
        logic b;
        b = ready_lfsr[0];
        ready_lfsr = lfsr_step(ready_lfsr);
        return b;
    endfunction

    // Expected record straight from the position decode map
    function automatic csr_index_cfg_t expected_record(input logic [7:0][31:0] w);
        csr_index_cfg_t r;
        r.increment     = w[0][0];
        r.decrement     = w[0][1];
        r.mode_sequence = w[0][2];
        r.mode_buffer   = w[0][3];
        r.mode_break    = w[0][4];
        r.index_start   = w[1];
        r.index_end     = w[2];
        r.stride        = w[3];
        r.granularity   = w[4][4:0];
        r.direction     = w[4][31];
        r.cmd           = w[5][3:0];
        r.id_module     = w[5][7:4];
        r.id_channel    = w[5][11:8];
        r.array_size    = w[6];
        r.const_value   = w[7];
        return r;
    endfunction

    task automatic new_words(output logic [7:0][31:0] w);
        for (int i = 0; i < 8; i++) begin
            w[i] = take_data_bits(32);
        end
    endtask

    task automatic send_word(input logic [7:0] off, input logic [31:0] data, input bit gaps);
        int gap;
        gap = gaps ? int'(take_data_bits(2)) : 0;
        @(negedge ap_clk);
        repeat (gap) begin
            resp_valid = 1'b0;
            @(negedge ap_clk);
        end
        resp_valid  = 1'b1;
        resp.offset = off;
        resp.data   = data;
        @(posedge ap_clk);
        while (!resp_ready) @(posedge ap_clk);
    endtask

    task automatic release_bus();
        @(negedge ap_clk);
        resp_valid = 1'b0;
    endtask

    // Full in-order sequence; out-of-window words optionally mixed in
    task automatic send_sequence(input logic [7:0][31:0] w, input bit gaps, input bit strays);
        logic [7:0] stray;
        for (int i = 0; i < 8; i++) begin
            if (strays && take_data_bits(1)) begin
                stray = take_data_bits(1) ? 8'(take_data_bits(4))
                                          : 8'd24 + 8'(take_data_bits(7));
                send_word(stray, take_data_bits(32), gaps);
            end
            if (i == 7) begin
                exp_q.push_back(expected_record(w));
            end
            send_word(BASE + 8'(i), w[i], gaps);
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(posedge ap_clk);
        repeat (10) @(posedge ap_clk);
    endtask

    // --------------------
    // Output checker
    // --------------------
    always @(posedge ap_clk) begin
        if (!areset_csr_index_generator && cfg_valid && cfg_ready) begin
            assert (exp_q.size() != 0) else
                stop_with_error("A record came out while none was expected");
            if (exp_q.size() != 0) begin
                exp_rec = exp_q.pop_front();
                rec_count++;
                assert (cfg === exp_rec) else
                    stop_with_error($sformatf("mismatch at %0t: record %0d got %h, expected %h",
                                              $time, rec_count, cfg, exp_rec));
            end
        end
    end

    initial begin
        cfg_ready = 1'b1;
        forever begin
            @(negedge ap_clk);
            cfg_ready = random_ready ? take_ready_bit() : 1'b1;
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_SEQ * 40 + 200));
        stop_with_error("Timeout, the records did not all arrive in time");
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        areset_csr_index_generator = 1'b1;
        resp_valid = 1'b0;
        resp       = '0;

        // Reset, then a sequence held back at its last word
        repeat (2) begin
            @(negedge ap_clk);
            assert (cfg_valid === 1'b0) else
                stop_with_error("cfg_valid was not low during reset");
        end
        areset_csr_index_generator = 1'b0;
        assert (resp_ready === 1'b0) else
            stop_with_error("resp_ready was high in the first cycle after reset");
        @(negedge ap_clk);
        assert (resp_ready === 1'b1) else
            stop_with_error("resp_ready did not rise one cycle after reset");
        new_words(words);
        for (int i = 0; i < 7; i++) begin
            send_word(BASE + 8'(i), words[i], 1'b0);
        end
        release_bus();
        repeat (20) @(posedge ap_clk);
        exp_q.push_back(expected_record(words));
        send_word(BASE + 8'd7, words[7], 1'b0);
        release_bus();
        wait_drained();

        // Plain sequence, then one with strays
        new_words(words);
        send_sequence(words, 1'b0, 1'b0);
        release_bus();
        wait_drained();
        new_words(words);
        send_sequence(words, 1'b0, 1'b1);
        release_bus();
        wait_drained();

        // Position 3 skipped, no record expected
        new_words(words);
        for (int i = 0; i < 8; i++) begin
            if (i != 3) begin
                send_word(BASE + 8'(i), words[i], 1'b0);
            end
        end
        release_bus();
        repeat (30) @(posedge ap_clk);

        // Restart at position 0 mid-way
        new_words(early_words);
        for (int i = 0; i < 3; i++) begin
            send_word(BASE + 8'(i), early_words[i], 1'b0);
        end
        new_words(words);
        send_sequence(words, 1'b0, 1'b0);
        release_bus();
        wait_drained();

        // Random gaps and back-pressure
        random_ready = 1'b1;
        for (int s = 0; s < 30; s++) begin
            new_words(words);
            send_sequence(words, 1'b1, 1'b0);
        end
        release_bus();
        wait_drained();
        random_ready = 1'b0;
        repeat (20) @(posedge ap_clk);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/csr_cfg_pkg.sv
verilog/response_window_filter.sv
verilog/config_assembler.sv
verilog/config_fifo.sv
verilog/csr_index_configure.sv
dv/tb_csr_index_configure.sv

/* Makefile */
# Verilator simulation of the CSR index configuration loader

VERILATOR ?= verilator
TOP       ?= tb_csr_index_configure
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
